//--- project.f
source/rammodel_pkg.sv
source/ready_valid_fork.sv
source/rammodel_tracker.sv
source/rammodel_tm_fixed.sv
source/rammodel_backend.sv
source/rammodel_frontend.sv
source/rammodel_top.sv
sim/rammodel_sva.sv
sim/rammodel_tb.sv

//--- sim/rammodel_sva.sv
`default_nettype none

module rammodel_sva import rammodel_pkg::*; #(
    parameter int MAX_INFLIGHT = 8
) (
    input wire  target_clk,
    input wire  rst,
    input wire  arvalid,
    input wire  arready,
    input wire  awvalid,
    input wire  awready,
    input wire  rvalid,
    input wire  rready,
    input wire  id_t rid,
    input wire  data_t rdata,
    input wire  bvalid,
    input wire  bready,
    input wire  id_t bid
);
    timeunit 1ns;
    timeprecision 1ps;

    int   outstanding;
    logic r_shown;  // current R beat was already on the bus a cycle earlier
    logic b_shown;

    // a response counts as retired on its first cycle, where the tracker takes its copy
    always_ff @(posedge target_clk) begin
        if (rst) begin
            outstanding <= 0;
            r_shown     <= 1'b0;
            b_shown     <= 1'b0;
        end else begin
            outstanding <= outstanding + int'(arvalid && arready) + int'(awvalid && awready)
                         - int'(rvalid && !r_shown) - int'(bvalid && !b_shown);
            r_shown <= rvalid && !rready;
            b_shown <= bvalid && !bready;
        end
    end

    r_hold: assert property (@(posedge target_clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata))
        else $error("rvalid dropped or R payload changed before the transfer");

    b_hold: assert property (@(posedge target_clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bid))
        else $error("bvalid dropped or bid changed before the transfer");

    inflight_limit: assert property (@(posedge target_clk) disable iff (rst)
        outstanding <= MAX_INFLIGHT)
        else $error("more than %0d requests in flight", MAX_INFLIGHT);

endmodule

bind rammodel_top rammodel_sva #(.MAX_INFLIGHT(MAX_INFLIGHT)) rammodel_sva_i (
    .target_clk (target_clk),
    .rst        (rst),
    .arvalid    (arvalid),
    .arready    (arready),
    .awvalid    (awvalid),
    .awready    (awready),
    .rvalid     (rvalid),
    .rready     (rready),
    .rid        (rid),
    .rdata      (rdata),
    .bvalid     (bvalid),
    .bready     (bready),
    .bid        (bid)
);

`default_nettype wire

//--- sim/rammodel_tb.sv
`default_nettype none

module rammodel_tb import rammodel_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_INFLIGHT = 8;
    localparam int R_DELAY      = 25;
    localparam int W_DELAY      = 3;
    localparam int NWORDS       = 32;  // words touched by the traffic
    localparam int N_MIX        = 40;  // reads and writes each in the random tests
    localparam int N_REQ        = 3 * NWORDS + 4 * N_MIX;
    localparam int TIMEOUT      = N_REQ * (R_DELAY + MAX_INFLIGHT + 20);

    logic  target_clk = 1'b0;
    logic  rst;
    logic  arvalid, arready, awvalid, awready, wvalid, wready;
    logic  rvalid, rready, bvalid, bready;
    id_t   arid, awid, rid, bid;
    addr_t araddr, awaddr;
    data_t wdata, rdata;
    strb_t wstrb;

    data_t       ref_mem [NWORDS];
    int          rd_pend [NWORDS];  // reads outstanding per word
    int          wr_pend [NWORDS];
    id_t         exp_rid [$];
    data_t       exp_rdata [$];
    int          exp_rtime [$];
    int          exp_rword [$];
    id_t         exp_bid [$];
    int          exp_btime [$];
    int          exp_bword [$];
    int          aw_word;
    data_t       aw_data;
    strb_t       aw_strb;
    logic [31:0] seed;
    int          cycle;
    int          watchdog;
    int          checks;
    int          errors;
    int          outstanding;
    logic        r_shown;
    logic        b_shown;
    string       test_name;
    int          left_wr, left_rd, wr_idx, rd_idx;
    bit          sweep, full_strb, stall;
    int          drain_first_error;

    rammodel_top #(
        .ADDR_WIDTH   (ADDR_BITS),
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) rammodel_top_i (.*);

    always #20 target_clk = ~target_clk;

    always @(posedge target_clk) begin
        watchdog <= watchdog + 1;
        if (watchdog == TIMEOUT) begin
            $display("timeout, the traffic did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < STRB_BITS; i++) begin
            if (strb[i]) merged[8*i +: 8] = new_word[8*i +: 8];
        end
        return merged;
    endfunction

    task automatic report(input string msg);
        $display("%s: %s", test_name, msg);
        errors++;
    endtask

    task automatic check_data(input string what, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            $display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic check_id(input string what, input id_t expected, input id_t actual);
        checks++;
        if (actual !== expected) begin
            $display("** Error %s: %s expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic take_read_response();
        int issued_at;
        if (exp_rid.size() == 0) begin
            report("an R beat arrived with no read outstanding");
        end else begin
            check_id("rid", exp_rid.pop_front(), rid);
            check_data("rdata", exp_rdata.pop_front(), rdata);
            issued_at = exp_rtime.pop_front();
            rd_pend[exp_rword.pop_front()]--;
            if (cycle - issued_at < R_DELAY + 1)
                report($sformatf("R came %0d cycles after its AR", cycle - issued_at));
        end
    endtask

    task automatic take_write_response();
        int issued_at;
        if (exp_bid.size() == 0) begin
            report("a B beat arrived with no write outstanding");
        end else begin
            check_id("bid", exp_bid.pop_front(), bid);
            issued_at = exp_btime.pop_front();
            wr_pend[exp_bword.pop_front()]--;
            if (cycle - issued_at < W_DELAY + 1)
                report($sformatf("B came %0d cycles after its AW and W", cycle - issued_at));
        end
    endtask

    // one clock: sample what the edge transferred, then drive the next inputs
    task automatic step();
        bit          ar_free;
        bit          wr_free;
        int          w;
        data_t       d;
        strb_t       s;
        logic [31:0] rnd;
        @(posedge target_clk);
        cycle++;
        ar_free = !arvalid || arready;
        wr_free = (!awvalid || awready) && (!wvalid || wready);
        if (arvalid && arready) begin
            arvalid <= 1'b0;
            outstanding++;
        end
        if (awvalid && awready) begin
            awvalid <= 1'b0;
            outstanding++;
            ref_mem[aw_word] = merge_bytes(ref_mem[aw_word], aw_data, aw_strb);
        end
        if (wvalid && wready) wvalid <= 1'b0;
        if (rvalid && !r_shown) outstanding--;  // tracker retires on first sight
        if (bvalid && !b_shown) outstanding--;
        r_shown = rvalid && !rready;
        b_shown = bvalid && !bready;
        if (outstanding > MAX_INFLIGHT)
            report($sformatf("%0d requests in flight, above the limit", outstanding));
        if (rvalid && rready) take_read_response();
        if (bvalid && bready) take_write_response();

        rnd = next_random();
        rready <= stall ? rnd[12] : 1'b1;
        bready <= stall ? rnd[13] : 1'b1;
        w = sweep ? rd_idx % NWORDS : int'(rnd[31:16]) % NWORDS;
        if (ar_free && left_rd > 0 && rnd[9:8] != 2'b00 && wr_pend[w] == 0) begin
            arvalid <= 1'b1;
            arid    <= id_t'(rnd[3:0]);
            araddr  <= addr_t'(w * 4);
            exp_rid.push_back(id_t'(rnd[3:0]));
            exp_rdata.push_back(ref_mem[w]);
            exp_rtime.push_back(cycle + 1);
            exp_rword.push_back(w);
            rd_pend[w]++;
            left_rd--;
            rd_idx++;
        end

        rnd = next_random();
        w = sweep ? wr_idx % NWORDS : int'(rnd[31:16]) % NWORDS;
        if (wr_free && left_wr > 0 && rnd[11:10] != 2'b00 && rd_pend[w] == 0) begin
            d = next_random();
            s = full_strb ? '1 : strb_t'(rnd[7:4]);
            awvalid <= 1'b1;
            awid    <= id_t'(rnd[3:0]);
            awaddr  <= addr_t'(w * 4);
            wvalid  <= 1'b1;
            wdata   <= d;
            wstrb   <= s;
            aw_word = w;
            aw_data = d;
            aw_strb = s;
            exp_bid.push_back(id_t'(rnd[3:0]));
            exp_btime.push_back(cycle + 1);
            exp_bword.push_back(w);
            wr_pend[w]++;
            left_wr--;
            wr_idx++;
        end
    endtask

    task automatic run_traffic(input string name, input int n_wr, input int n_rd,
                               input bit in_order, input bit whole_words, input bit throttle);
        int first_error;
        first_error = errors;
        test_name = name;
        left_wr   = n_wr;
        left_rd   = n_rd;
        wr_idx    = 0;
        rd_idx    = 0;
        sweep     = in_order;
        full_strb = whole_words;
        stall     = throttle;
        while (left_wr > 0 || left_rd > 0 || exp_rid.size() > 0 || exp_bid.size() > 0) begin
            step();
        end
        $display("test %s finished with %0d errors", name, errors - first_error);
    endtask

    initial begin
        seed        = 32'h136a_8ede;
        rst         = 1'b1;
        arvalid     = 1'b0;
        arid        = '0;
        araddr      = '0;
        awvalid     = 1'b0;
        awid        = '0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        wstrb       = '0;
        rready      = 1'b0;
        bready      = 1'b0;
        cycle       = 0;
        watchdog    = 0;
        checks      = 0;
        errors      = 0;
        outstanding = 0;
        r_shown     = 1'b0;
        b_shown     = 1'b0;
        for (int i = 0; i < NWORDS; i++) begin
            rd_pend[i] = 0;
            wr_pend[i] = 0;
        end
        repeat (5) @(posedge target_clk);
        rst <= 1'b0;

        run_traffic("fill", NWORDS, 0, 1'b1, 1'b1, 1'b0);
        run_traffic("strobe_write", NWORDS, 0, 1'b1, 1'b0, 1'b0);
        run_traffic("read_back", 0, NWORDS, 1'b1, 1'b0, 1'b0);
        run_traffic("mixed", N_MIX, N_MIX, 1'b0, 1'b0, 1'b0);
        run_traffic("backpressure", N_MIX, N_MIX, 1'b0, 1'b0, 1'b1);
        // quiet bus, any further beat here is a duplicate
        test_name = "drain";
        stall     = 1'b0;
        drain_first_error = errors;
        repeat (2 * R_DELAY) step();
        $display("test %s finished with %0d errors", test_name, errors - drain_first_error);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/rammodel_backend.sv
`default_nettype none

module rammodel_backend import rammodel_pkg::*; #(
    parameter int ADDR_WIDTH   = 10,
    parameter int MAX_INFLIGHT = 8
) (
    input  wire   target_clk,
    input  wire   rst,
    input  wire   cmd_valid,
    output logic  cmd_ready,
    input  wire   cmd_write,
    input  wire   id_t cmd_id,
    input  wire   addr_t cmd_addr,
    input  wire   wd_valid,
    output logic  wd_ready,
    input  wire   data_t wd_data,
    input  wire   strb_t wd_strb,
    input  wire   rreq_valid,
    input  wire   breq_valid,
    output logic  be_rvalid,
    input  wire   be_rready,
    output id_t   be_rid,
    output data_t be_rdata,
    output logic  be_bvalid,
    input  wire   be_bready,
    output id_t   be_bid
);

    localparam int DEPTH = 2 ** (ADDR_WIDTH - 2);
    localparam int PW    = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CW    = $clog2(MAX_INFLIGHT + 1);

    data_t         mem [DEPTH];
    id_t           rq_id [2**PW];  // reads waiting for release
    addr_t         rq_addr [2**PW];
    logic [PW-1:0] rq_wr;
    logic [PW-1:0] rq_rd;
    logic [CW-1:0] rq_cnt;
    id_t           aq_id [2**PW];  // write commands
    addr_t         aq_addr [2**PW];
    logic [PW-1:0] aq_wr;
    logic [PW-1:0] aq_rd;
    logic [CW-1:0] aq_cnt;
    data_t         dq_data [2**PW];  // write data, paired with aq by order
    strb_t         dq_strb [2**PW];
    logic [PW-1:0] dq_wr;
    logic [PW-1:0] dq_rd;
    logic [CW-1:0] dq_cnt;
    logic [CW-1:0] rel_r;
    logic [CW-1:0] rel_b;
    logic          rq_push;
    logic          aq_push;
    logic          dq_push;
    logic          r_load;
    logic          b_load;

    assign cmd_ready = cmd_write ? aq_cnt != CW'(MAX_INFLIGHT) : rq_cnt != CW'(MAX_INFLIGHT);
    assign wd_ready  = dq_cnt != CW'(MAX_INFLIGHT);
    assign rq_push   = cmd_valid && cmd_ready && !cmd_write;
    assign aq_push   = cmd_valid && cmd_ready && cmd_write;
    assign dq_push   = wd_valid && wd_ready;

    // a release pulse can be used in the cycle it arrives
    assign r_load = (rel_r != '0 || rreq_valid) && rq_cnt != '0 && (!be_rvalid || be_rready);
    assign b_load = (rel_b != '0 || breq_valid) && aq_cnt != '0 && dq_cnt != '0
                  && (!be_bvalid || be_bready);

    always_ff @(posedge target_clk) begin
        if (rst) begin
            be_rvalid <= 1'b0;
            be_bvalid <= 1'b0;
            {rq_wr, rq_rd, rq_cnt} <= '0;
            {aq_wr, aq_rd, aq_cnt} <= '0;
            {dq_wr, dq_rd, dq_cnt} <= '0;
            rel_r <= '0;
            rel_b <= '0;
        end else begin
            if (r_load) be_rvalid <= 1'b1;
            else if (be_rready) be_rvalid <= 1'b0;
            if (b_load) be_bvalid <= 1'b1;
            else if (be_bready) be_bvalid <= 1'b0;
            rq_wr  <= rq_wr + PW'(rq_push);
            rq_rd  <= rq_rd + PW'(r_load);
            rq_cnt <= rq_cnt + CW'(rq_push) - CW'(r_load);
            aq_wr  <= aq_wr + PW'(aq_push);
            aq_rd  <= aq_rd + PW'(b_load);
            aq_cnt <= aq_cnt + CW'(aq_push) - CW'(b_load);
            dq_wr  <= dq_wr + PW'(dq_push);
            dq_rd  <= dq_rd + PW'(b_load);
            dq_cnt <= dq_cnt + CW'(dq_push) - CW'(b_load);
            rel_r  <= rel_r + CW'(rreq_valid) - CW'(r_load);
            rel_b  <= rel_b + CW'(breq_valid) - CW'(b_load);
        end
    end

    always_ff @(posedge target_clk) begin
        if (rq_push) begin
            rq_id[rq_wr]   <= cmd_id;
            rq_addr[rq_wr] <= cmd_addr;
        end
        if (aq_push) begin
            aq_id[aq_wr]   <= cmd_id;
            aq_addr[aq_wr] <= cmd_addr;
        end
        if (dq_push) begin
            dq_data[dq_wr] <= wd_data;
            dq_strb[dq_wr] <= wd_strb;
        end
        if (r_load) begin
            be_rid   <= rq_id[rq_rd];
            be_rdata <= mem[rq_addr[rq_rd][ADDR_WIDTH-1:2]];  // old word on a same-cycle write
        end
        if (b_load) be_bid <= aq_id[aq_rd];
        for (int i = 0; i < STRB_BITS; i++) begin
            if (b_load && dq_strb[dq_rd][i]) begin
                mem[aq_addr[aq_rd][ADDR_WIDTH-1:2]][8*i +: 8] <= dq_data[dq_rd][8*i +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rammodel_frontend.sv
`default_nettype none

module rammodel_frontend import rammodel_pkg::*; #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3
) (
    input  wire   target_clk,
    input  wire   rst,
    input  wire   arvalid,
    output logic  arready,
    input  wire   id_t arid,
    input  wire   addr_t araddr,
    input  wire   awvalid,
    output logic  awready,
    input  wire   id_t awid,
    input  wire   addr_t awaddr,
    input  wire   wvalid,
    output logic  wready,
    input  wire   data_t wdata,
    input  wire   strb_t wstrb,
    output logic  rvalid,
    input  wire   rready,
    output id_t   rid,
    output data_t rdata,
    output logic  bvalid,
    input  wire   bready,
    output id_t   bid,
    output logic  cmd_valid,
    input  wire   cmd_ready,
    output logic  cmd_write,
    output id_t   cmd_id,
    output addr_t cmd_addr,
    output logic  wd_valid,
    input  wire   wd_ready,
    output data_t wd_data,
    output strb_t wd_strb,
    input  wire   be_rvalid,
    output logic  be_rready,
    input  wire   id_t be_rid,
    input  wire   data_t be_rdata,
    input  wire   be_bvalid,
    output logic  be_bready,
    input  wire   id_t be_bid,
    output logic  rreq_valid,
    output logic  breq_valid
);

    logic trk_arvalid, trk_arready, tm_arvalid, tm_arready;
    logic trk_awvalid, trk_awready, tm_awvalid, tm_awready;
    logic trk_wvalid, trk_wready, tm_wvalid, tm_wready;
    logic trk_rvalid, trk_rready, trk_bvalid, trk_bready;

    // target requests go to both the tracker and the timing model
    ready_valid_fork #(.BRANCHES(2)) fork_ar (
        .target_clk (target_clk),
        .rst        (rst),
        .s_valid    (arvalid),
        .s_ready    (arready),
        .m_valid    ({tm_arvalid, trk_arvalid}),
        .m_ready    ({tm_arready, trk_arready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_aw (
        .target_clk (target_clk),
        .rst        (rst),
        .s_valid    (awvalid),
        .s_ready    (awready),
        .m_valid    ({tm_awvalid, trk_awvalid}),
        .m_ready    ({tm_awready, trk_awready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_w (
        .target_clk (target_clk),
        .rst        (rst),
        .s_valid    (wvalid),
        .s_ready    (wready),
        .m_valid    ({tm_wvalid, trk_wvalid}),
        .m_ready    ({tm_wready, trk_wready})
    );

    rammodel_tracker #(.MAX_INFLIGHT(MAX_INFLIGHT)) tracker (
        .target_clk (target_clk),
        .rst        (rst),
        .arvalid    (trk_arvalid),
        .arready    (trk_arready),
        .arid       (arid),
        .araddr     (araddr),
        .awvalid    (trk_awvalid),
        .awready    (trk_awready),
        .awid       (awid),
        .awaddr     (awaddr),
        .wvalid     (trk_wvalid),
        .wready     (trk_wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .rvalid     (trk_rvalid),
        .rready     (trk_rready),
        .bvalid     (trk_bvalid),
        .bready     (trk_bready),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_write  (cmd_write),
        .cmd_id     (cmd_id),
        .cmd_addr   (cmd_addr),
        .wd_valid   (wd_valid),
        .wd_ready   (wd_ready),
        .wd_data    (wd_data),
        .wd_strb    (wd_strb)
    );

    rammodel_tm_fixed #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) timing_model (
        .target_clk (target_clk),
        .rst        (rst),
        .arvalid    (tm_arvalid),
        .arready    (tm_arready),
        .awvalid    (tm_awvalid),
        .awready    (tm_awready),
        .wvalid     (tm_wvalid),
        .wready     (tm_wready),
        .rreq_valid (rreq_valid),
        .breq_valid (breq_valid)
    );

    // backend responses go back to the target and retire in the tracker
    ready_valid_fork #(.BRANCHES(2)) fork_r (
        .target_clk (target_clk),
        .rst        (rst),
        .s_valid    (be_rvalid),
        .s_ready    (be_rready),
        .m_valid    ({rvalid, trk_rvalid}),
        .m_ready    ({rready, trk_rready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_b (
        .target_clk (target_clk),
        .rst        (rst),
        .s_valid    (be_bvalid),
        .s_ready    (be_bready),
        .m_valid    ({bvalid, trk_bvalid}),
        .m_ready    ({bready, trk_bready})
    );

    assign rid   = be_rid;
    assign rdata = be_rdata;
    assign bid   = be_bid;

endmodule

`default_nettype wire

//--- source/rammodel_pkg.sv
`default_nettype none

package rammodel_pkg;

    localparam int ADDR_BITS = 10;  // 256 words of 4 bytes
    localparam int DATA_BITS = 32;
    localparam int STRB_BITS = DATA_BITS / 8;
    localparam int ID_BITS   = 4;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [STRB_BITS-1:0] strb_t;
    typedef logic [ID_BITS-1:0]   id_t;

    // pairing of AW with W before the write delay starts
    typedef enum logic [1:0] {
        TM_IDLE,
        TM_HAVE_AW,
        TM_HAVE_W,
        TM_COUNTING
    } tm_state_t;

endpackage

`default_nettype wire

//--- source/rammodel_tm_fixed.sv
`default_nettype none

module rammodel_tm_fixed import rammodel_pkg::*; #(
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3   // at least 2, the pair is queued a cycle late
) (
    input  wire  target_clk,
    input  wire  rst,
    input  wire  arvalid,
    output logic arready,
    input  wire  awvalid,
    output logic awready,
    input  wire  wvalid,
    output logic wready,
    output logic rreq_valid,
    output logic breq_valid
);

    localparam int PW = (MAX_INFLIGHT > 1) ? $clog2(MAX_INFLIGHT) : 1;
    localparam int CW = $clog2(MAX_INFLIGHT + 1);
    localparam int TW = 16;  // due times compare by equality so wrap is harmless

    logic [TW-1:0] now;
    logic [TW-1:0] r_due [2**PW];
    logic [PW-1:0] r_wr;
    logic [PW-1:0] r_rd;
    logic [CW-1:0] r_cnt;
    logic [TW-1:0] w_due [2**PW];
    logic [PW-1:0] w_wr;
    logic [PW-1:0] w_rd;
    logic [CW-1:0] w_cnt;
    logic [TW-1:0] w_pend;
    tm_state_t     state;
    logic          w_space;
    logic          aw_fire;
    logic          w_fire;
    logic          pair_done;

    assign w_space = w_cnt != CW'(MAX_INFLIGHT);
    assign arready = r_cnt != CW'(MAX_INFLIGHT);
    assign awready = (state == TM_IDLE || state == TM_HAVE_W) && w_space;
    assign wready  = (state == TM_IDLE || state == TM_HAVE_AW) && w_space;
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    assign pair_done = (state == TM_IDLE && aw_fire && w_fire)
                     || (state == TM_HAVE_AW && w_fire)
                     || (state == TM_HAVE_W && aw_fire);

    // entries are pushed in due order, so only the head can be due
    assign rreq_valid = r_cnt != '0 && r_due[r_rd] == now;
    assign breq_valid = w_cnt != '0 && w_due[w_rd] == now;

    always_ff @(posedge target_clk) begin
        if (rst) begin
            now   <= '0;
            state <= TM_IDLE;
            r_wr  <= '0;
            r_rd  <= '0;
            r_cnt <= '0;
            w_wr  <= '0;
            w_rd  <= '0;
            w_cnt <= '0;
        end else begin
            now <= now + 1'b1;
            case (state)
                TM_IDLE: begin
                    if (pair_done) state <= TM_COUNTING;
                    else if (aw_fire) state <= TM_HAVE_AW;
                    else if (w_fire) state <= TM_HAVE_W;
                end
                TM_HAVE_AW, TM_HAVE_W: begin
                    if (pair_done) state <= TM_COUNTING;
                end
                default: state <= TM_IDLE;  // the pending due time is queued here
            endcase
            r_wr  <= r_wr + PW'(arvalid && arready);
            r_rd  <= r_rd + PW'(rreq_valid);
            r_cnt <= r_cnt + CW'(arvalid && arready) - CW'(rreq_valid);
            w_wr  <= w_wr + PW'(state == TM_COUNTING);
            w_rd  <= w_rd + PW'(breq_valid);
            w_cnt <= w_cnt + CW'(state == TM_COUNTING) - CW'(breq_valid);
        end
    end

    always_ff @(posedge target_clk) begin
        if (arvalid && arready) r_due[r_wr] <= now + TW'(R_DELAY);
        if (pair_done) w_pend <= now + TW'(W_DELAY);
        if (state == TM_COUNTING) w_due[w_wr] <= w_pend;
    end

endmodule

`default_nettype wire

//--- source/rammodel_top.sv
`default_nettype none

module rammodel_top import rammodel_pkg::*; #(
    parameter int ADDR_WIDTH   = ADDR_BITS,
    parameter int MAX_INFLIGHT = 8,
    parameter int R_DELAY      = 25,
    parameter int W_DELAY      = 3
) (
    input  wire   target_clk,
    input  wire   rst,
    input  wire   arvalid,
    output logic  arready,
    input  wire   id_t arid,
    input  wire   addr_t araddr,
    input  wire   awvalid,
    output logic  awready,
    input  wire   id_t awid,
    input  wire   addr_t awaddr,
    input  wire   wvalid,
    output logic  wready,
    input  wire   data_t wdata,
    input  wire   strb_t wstrb,
    output logic  rvalid,
    input  wire   rready,
    output id_t   rid,
    output data_t rdata,
    output logic  bvalid,
    input  wire   bready,
    output id_t   bid
);

    logic  cmd_valid;
    logic  cmd_ready;
    logic  cmd_write;
    id_t   cmd_id;
    addr_t cmd_addr;
    logic  wd_valid;
    logic  wd_ready;
    data_t wd_data;
    strb_t wd_strb;
    logic  be_rvalid;
    logic  be_rready;
    id_t   be_rid;
    data_t be_rdata;
    logic  be_bvalid;
    logic  be_bready;
    id_t   be_bid;
    logic  rreq_valid;  // release pulses from the timing model
    logic  breq_valid;

    // every port of both blocks has a same-named signal here
    rammodel_frontend #(
        .MAX_INFLIGHT (MAX_INFLIGHT),
        .R_DELAY      (R_DELAY),
        .W_DELAY      (W_DELAY)
    ) frontend (.*);

    rammodel_backend #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .MAX_INFLIGHT (MAX_INFLIGHT)
    ) backend (.*);

endmodule

`default_nettype wire

//--- source/rammodel_tracker.sv
`default_nettype none

module rammodel_tracker import rammodel_pkg::*; #(
    parameter int MAX_INFLIGHT = 8
) (
    input  wire   target_clk,
    input  wire   rst,
    input  wire   arvalid,
    output logic  arready,
    input  wire   id_t arid,
    input  wire   addr_t araddr,
    input  wire   awvalid,
    output logic  awready,
    input  wire   id_t awid,
    input  wire   addr_t awaddr,
    input  wire   wvalid,
    output logic  wready,
    input  wire   data_t wdata,
    input  wire   strb_t wstrb,
    input  wire   rvalid,
    output logic  rready,
    input  wire   bvalid,
    output logic  bready,
    output logic  cmd_valid,
    input  wire   cmd_ready,
    output logic  cmd_write,
    output id_t   cmd_id,
    output addr_t cmd_addr,
    output logic  wd_valid,
    input  wire   wd_ready,
    output data_t wd_data,
    output strb_t wd_strb
);

    localparam int CW = $clog2(MAX_INFLIGHT + 1);

    logic          up;  // stays low through reset so the target sees no ready
    logic [CW-1:0] inflight;
    logic          slot_free;
    logic          take_ar;
    logic          take_aw;

    // the command register can load when it is empty or draining this cycle
    assign slot_free = up && (!cmd_valid || cmd_ready) && inflight != CW'(MAX_INFLIGHT);
    assign arready   = slot_free;
    assign awready   = slot_free && !arvalid;  // reads win a tie
    assign take_ar   = arvalid && arready;
    assign take_aw   = awvalid && awready;

    assign wd_valid = up && wvalid;
    assign wready   = up && wd_ready;
    assign wd_data  = wdata;
    assign wd_strb  = wstrb;

    assign rready = 1'b1;
    assign bready = 1'b1;

    always_ff @(posedge target_clk) begin
        if (rst) begin
            up        <= 1'b0;
            cmd_valid <= 1'b0;
            inflight  <= '0;
        end else begin
            up <= 1'b1;
            if (take_ar || take_aw) begin
                cmd_valid <= 1'b1;
            end else if (cmd_ready) begin
                cmd_valid <= 1'b0;
            end
            inflight <= inflight + CW'(take_ar || take_aw)
                      - CW'(rvalid && rready) - CW'(bvalid && bready);
        end
    end

    always_ff @(posedge target_clk) begin
        if (take_ar) begin
            cmd_write <= 1'b0;
            cmd_id    <= arid;
            cmd_addr  <= araddr;
        end else if (take_aw) begin
            cmd_write <= 1'b1;
            cmd_id    <= awid;
            cmd_addr  <= awaddr;
        end
    end

endmodule

`default_nettype wire

//--- source/ready_valid_fork.sv
`default_nettype none

module ready_valid_fork #(
    parameter int BRANCHES = 2
) (
    input  wire                 target_clk,
    input  wire                 rst,
    input  wire                 s_valid,
    output logic                s_ready,
    output logic [BRANCHES-1:0] m_valid,
    input  wire  [BRANCHES-1:0] m_ready
);

    logic [BRANCHES-1:0] done;  // branches that already took the current item

    assign m_valid = {BRANCHES{s_valid}} & ~done;
    assign s_ready = &(done | m_ready);

    always_ff @(posedge target_clk) begin
        if (rst) begin
            done <= '0;
        end else if (s_valid && s_ready) begin
            done <= '0;  // every branch has it, start over for the next item
        end else begin
            done <= done | (m_valid & m_ready);
        end
    end

endmodule

`default_nettype wire
